//--- build.f
source/z80_pkg.sv
source/z80_registers.sv
source/z80_alu8.sv
source/z80_cmd_sequencer.sv
source/z80_datapath.sv
tb/z80_datapath_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module z80_datapath_tb -o z80_sim
./obj_dir/z80_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0

//--- source/z80_alu8.sv
`timescale 1ns/10ps
`default_nettype none

module z80_alu8 (
  input  z80_pkg::alu_fn_t fn,
  input  logic [7:0]       a,
  input  logic [7:0]       b,
  input  logic [7:0]       flags_in,
  output logic [7:0]       result,
  output logic [7:0]       flags_out
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic       half_add;
  logic       half_sub;

  // Nine bits so the top bit is the carry or borrow
  assign sum = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};
  assign half_add = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'h0f;
  assign half_sub = a[3:0] < b[3:0];

  always_comb begin
    flags_out = flags_in;
    case (fn)
      z80_pkg::ALU_ADD: begin
        result = sum[7:0];
        flags_out[z80_pkg::FLAG_H] = half_add;
        flags_out[z80_pkg::FLAG_PV] = (a[7] == b[7]) && (sum[7] != a[7]);
        flags_out[z80_pkg::FLAG_N] = 1'b0;
        flags_out[z80_pkg::FLAG_C] = sum[8];
      end
      z80_pkg::ALU_SUB: begin
        result = diff[7:0];
        flags_out[z80_pkg::FLAG_H] = half_sub;
        // Overflow when operand signs differ and the sign of a flips
        flags_out[z80_pkg::FLAG_PV] = (a[7] != b[7]) && (diff[7] != a[7]);
        flags_out[z80_pkg::FLAG_N] = 1'b1;
        flags_out[z80_pkg::FLAG_C] = diff[8];
      end
      z80_pkg::ALU_AND: begin
        result = a & b;
        flags_out[z80_pkg::FLAG_H] = 1'b1;
        flags_out[z80_pkg::FLAG_PV] = ~^(a & b);
        flags_out[z80_pkg::FLAG_N] = 1'b0;
        flags_out[z80_pkg::FLAG_C] = 1'b0;
      end
      default: begin
        result = a ^ b;
        flags_out[z80_pkg::FLAG_H] = 1'b0;
        flags_out[z80_pkg::FLAG_PV] = ~^(a ^ b);
        flags_out[z80_pkg::FLAG_N] = 1'b0;
        flags_out[z80_pkg::FLAG_C] = 1'b0;
      end
    endcase
    flags_out[z80_pkg::FLAG_S] = result[7];
    flags_out[z80_pkg::FLAG_Z] = (result == 8'h00);
    // Undocumented bits follow the result
    flags_out[z80_pkg::FLAG_5] = result[5];
    flags_out[z80_pkg::FLAG_3] = result[3];
  end

endmodule

`default_nettype wire

//--- source/z80_cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module z80_cmd_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_req,
  input  z80_pkg::cmd_word_u   cmd_word,
  input  logic [15:0]          rd_in,
  input  logic [7:0]           alu_result,
  input  logic [7:0]           alu_flags,
  output logic                 cmd_ack,
  output logic [15:0]          rd_data,
  output z80_pkg::alu_fn_t     alu_fn,
  output logic                 write_en,
  output z80_pkg::reg_select_t dest,
  output logic [15:0]          wr_data,
  output z80_pkg::reg_select_t src1,
  output z80_pkg::reg_select_t src2,
  output logic                 f_wr,
  output logic [7:0]           f_in,
  output logic                 block_inc,
  output logic                 block_dec,
  output logic                 block_compare,
  output logic                 ex_de_hl,
  output logic                 ex_af_af2,
  output logic                 exx
);

  typedef enum logic [1:0] {IDLE, EXEC, ACK} state_t;

  state_t             state;
  z80_pkg::cmd_word_u cmd_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      rd_data <= 16'h0000;
    end else begin
      case (state)
        IDLE: if (cmd_req) state <= EXEC;
        EXEC: begin
          state <= ACK;
          if (cmd_q.regs.op == z80_pkg::OP_READ) rd_data <= rd_in;
        end
        // Hold until the host drops its request
        default: if (!cmd_req) state <= IDLE;
      endcase
    end
  end

  // Command is latched when a request is taken
  always_ff @(posedge clk) begin
    if (state == IDLE && cmd_req) cmd_q <= cmd_word;
  end

  assign cmd_ack = (state == ACK);
  assign alu_fn = cmd_q.alu.fn;

  always_comb begin
    write_en = 1'b0;
    dest = z80_pkg::REG_B;
    wr_data = 16'h0000;
    src1 = z80_pkg::REG_B;
    src2 = z80_pkg::REG_B;
    f_wr = 1'b0;
    f_in = alu_flags;
    block_inc = 1'b0;
    block_dec = 1'b0;
    block_compare = 1'b0;
    ex_de_hl = 1'b0;
    ex_af_af2 = 1'b0;
    exx = 1'b0;
    if (state == EXEC) begin
      case (cmd_q.regs.op)
        z80_pkg::OP_LOAD: begin
          write_en = 1'b1;
          dest = cmd_q.regs.sel;
          wr_data = cmd_q.regs.imm;
        end
        z80_pkg::OP_READ: src1 = cmd_q.regs.sel;
        z80_pkg::OP_ALU: begin
          src1 = cmd_q.alu.src_a;
          src2 = cmd_q.alu.src_b;
          write_en = 1'b1;
          dest = cmd_q.alu.dest;
          wr_data = {8'h00, alu_result};
          f_wr = 1'b1;
        end
        z80_pkg::OP_BLOCK_INC: block_inc = 1'b1;
        z80_pkg::OP_BLOCK_DEC: block_dec = 1'b1;
        z80_pkg::OP_BLOCK_CPI: begin
          block_inc = 1'b1;
          block_compare = 1'b1;
        end
        z80_pkg::OP_BLOCK_CPD: begin
          block_dec = 1'b1;
          block_compare = 1'b1;
        end
        z80_pkg::OP_EX_DE_HL: ex_de_hl = 1'b1;
        z80_pkg::OP_EX_AF: ex_af_af2 = 1'b1;
        z80_pkg::OP_EXX: exx = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/z80_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module z80_datapath (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_req,
  input  z80_pkg::cmd_word_u cmd_word,
  output logic               cmd_ack,
  output logic [15:0]        rd_data,
  output logic [7:0]         flags
);

  logic                 write_en;
  z80_pkg::reg_select_t dest;
  logic [15:0]          wr_data;
  z80_pkg::reg_select_t src1;
  z80_pkg::reg_select_t src2;
  logic                 f_wr;
  logic [7:0]           f_in;
  logic                 block_inc;
  logic                 block_dec;
  logic                 block_compare;
  logic                 ex_de_hl;
  logic                 ex_af_af2;
  logic                 exx;
  logic [15:0]          out1;
  logic [15:0]          out2;
  z80_pkg::alu_fn_t     alu_fn;
  logic [7:0]           alu_result;
  logic [7:0]           alu_flags;

  z80_cmd_sequencer u_seq (
    .clk(clk), .reset(reset), .cmd_req(cmd_req), .cmd_word(cmd_word),
    .rd_in(out1), .alu_result(alu_result), .alu_flags(alu_flags),
    .cmd_ack(cmd_ack), .rd_data(rd_data), .alu_fn(alu_fn),
    .write_en(write_en), .dest(dest), .wr_data(wr_data), .src1(src1), .src2(src2),
    .f_wr(f_wr), .f_in(f_in), .block_inc(block_inc), .block_dec(block_dec),
    .block_compare(block_compare), .ex_de_hl(ex_de_hl), .ex_af_af2(ex_af_af2), .exx(exx)
  );

  // F goes straight out to the host and back into the ALU
  z80_registers u_regs (
    .clk(clk), .reset(reset), .write_en(write_en), .dest(dest), .wr_data(wr_data),
    .src1(src1), .src2(src2), .f_in(f_in), .f_wr(f_wr), .block_inc(block_inc),
    .block_dec(block_dec), .block_compare(block_compare), .ex_de_hl(ex_de_hl),
    .ex_af_af2(ex_af_af2), .exx(exx), .out1(out1), .out2(out2), .reg_f(flags)
  );

  z80_alu8 u_alu (
    .fn(alu_fn), .a(out1[7:0]), .b(out2[7:0]), .flags_in(flags),
    .result(alu_result), .flags_out(alu_flags)
  );

endmodule

`default_nettype wire

//--- source/z80_pkg.sv
`default_nettype none

package z80_pkg;

  // Register selector, one code per storage location
  typedef logic [4:0] reg_select_t;

  localparam reg_select_t REG_B  = 5'd0;
  localparam reg_select_t REG_C  = 5'd1;
  localparam reg_select_t REG_D  = 5'd2;
  localparam reg_select_t REG_E  = 5'd3;
  localparam reg_select_t REG_H  = 5'd4;
  localparam reg_select_t REG_L  = 5'd5;
  localparam reg_select_t REG_A  = 5'd7;
  localparam reg_select_t REG_BC = 5'd8;
  localparam reg_select_t REG_DE = 5'd9;
  localparam reg_select_t REG_HL = 5'd10;
  localparam reg_select_t REG_SP = 5'd11;
  localparam reg_select_t REG_AF = 5'd12;
  localparam reg_select_t REG_IX = 5'd13;
  localparam reg_select_t REG_IY = 5'd14;

  typedef enum logic [3:0] {
    OP_LOAD      = 4'd0,
    OP_READ      = 4'd1,
    OP_ALU       = 4'd2,
    OP_BLOCK_INC = 4'd3,
    OP_BLOCK_DEC = 4'd4,
    OP_BLOCK_CPI = 4'd5,
    OP_BLOCK_CPD = 4'd6,
    OP_EX_DE_HL  = 4'd7,
    OP_EX_AF     = 4'd8,
    OP_EXX       = 4'd9
  } cmd_op_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_fn_t;

  // Bit positions in F
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_5  = 5;
  localparam int FLAG_H  = 4;
  localparam int FLAG_3  = 3;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

  // Load and read commands
  typedef struct packed {
    cmd_op_t     op;
    reg_select_t sel;
    logic [2:0]  pad;
    logic [15:0] imm;
  } cmd_reg_t;

  // ALU commands, op stays in the top four bits
  typedef struct packed {
    cmd_op_t     op;
    alu_fn_t     fn;
    reg_select_t src_a;
    reg_select_t src_b;
    reg_select_t dest;
    logic [6:0]  pad;
  } cmd_alu_t;

  typedef union packed {
    cmd_reg_t regs;
    cmd_alu_t alu;
  } cmd_word_u;

endpackage

`default_nettype wire

//--- source/z80_registers.sv
`timescale 1ns/10ps
`default_nettype none

module z80_registers (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 write_en,
  input  z80_pkg::reg_select_t dest,
  input  logic [15:0]          wr_data,
  input  z80_pkg::reg_select_t src1,
  input  z80_pkg::reg_select_t src2,
  input  logic [7:0]           f_in,
  input  logic                 f_wr,
  input  logic                 block_inc,
  input  logic                 block_dec,
  input  logic                 block_compare,
  input  logic                 ex_de_hl,
  input  logic                 ex_af_af2,
  input  logic                 exx,
  output logic [15:0]          out1,
  output logic [15:0]          out2,
  output logic [7:0]           reg_f
);

  // Main set
  logic [15:0] af, bc, de, hl;
  // Shadow set
  logic [15:0] af2, bc2, de2, hl2;
  logic [15:0] ix, iy, sp;

  logic        writing_af;
  logic        do_f_wr;
  logic        do_write;
  logic        do_inc;
  logic        do_dec;
  logic        do_ex_de_hl;
  logic        do_ex_af;
  logic        do_exx;
  logic [15:0] new_bc;
  logic [7:0]  blk_flags;

  function automatic logic [15:0] read_sel(input z80_pkg::reg_select_t sel);
    logic [15:0] v;
    v = 16'h0000;
    case (sel)
      z80_pkg::REG_A:  v[7:0] = af[15:8];
      z80_pkg::REG_B:  v[7:0] = bc[15:8];
      z80_pkg::REG_C:  v[7:0] = bc[7:0];
      z80_pkg::REG_D:  v[7:0] = de[15:8];
      z80_pkg::REG_E:  v[7:0] = de[7:0];
      z80_pkg::REG_H:  v[7:0] = hl[15:8];
      z80_pkg::REG_L:  v[7:0] = hl[7:0];
      z80_pkg::REG_BC: v = bc;
      z80_pkg::REG_DE: v = de;
      z80_pkg::REG_HL: v = hl;
      z80_pkg::REG_SP: v = sp;
      z80_pkg::REG_AF: v = af;
      z80_pkg::REG_IX: v = ix;
      z80_pkg::REG_IY: v = iy;
      default:         v = 16'h0000;
    endcase
    return v;
  endfunction

  always_comb begin
    out1 = read_sel(src1);
    out2 = read_sel(src2);
  end

  assign reg_f = af[7:0];

  // A write to AF takes the flag byte itself
  assign writing_af = write_en && (dest == z80_pkg::REG_AF);

  // Each method only fires when no conflicting method is requested
  assign do_f_wr = f_wr && !block_inc && !block_dec && !writing_af && !ex_af_af2;
  assign do_write = write_en && !block_inc && !block_dec && !ex_de_hl && !ex_af_af2 && !exx;
  assign do_inc = block_inc && !write_en && !block_dec && !ex_de_hl && !ex_af_af2 &&
                  !exx && !f_wr;
  assign do_dec = block_dec && !write_en && !block_inc && !ex_de_hl && !ex_af_af2 &&
                  !exx && !f_wr;
  assign do_ex_de_hl = ex_de_hl && !write_en && !block_inc && !block_dec && !ex_af_af2 &&
                       !exx;
  assign do_ex_af = ex_af_af2 && !write_en && !block_inc && !block_dec && !ex_de_hl &&
                    !exx && !f_wr;
  assign do_exx = exx && !write_en && !block_inc && !block_dec && !ex_de_hl && !ex_af_af2;

  // Flags after a block step, PV tracks a nonzero count
  always_comb begin
    new_bc = bc - 16'd1;
    blk_flags = af[7:0];
    blk_flags[z80_pkg::FLAG_PV] = (new_bc != 16'h0000);
    if (!block_compare) begin
      blk_flags[z80_pkg::FLAG_H] = 1'b0;
      blk_flags[z80_pkg::FLAG_N] = 1'b0;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      af <= 16'h0000;
      bc <= 16'h0000;
      de <= 16'h0000;
      hl <= 16'h0000;
      af2 <= 16'h0000;
      bc2 <= 16'h0000;
      de2 <= 16'h0000;
      hl2 <= 16'h0000;
      ix <= 16'h0000;
      iy <= 16'h0000;
      sp <= 16'h0000;
    end else begin
      if (do_f_wr) begin
        af[7:0] <= f_in;
      end
      if (do_write) begin
        case (dest)
          z80_pkg::REG_A:  af[15:8] <= wr_data[7:0];
          z80_pkg::REG_B:  bc[15:8] <= wr_data[7:0];
          z80_pkg::REG_C:  bc[7:0] <= wr_data[7:0];
          z80_pkg::REG_D:  de[15:8] <= wr_data[7:0];
          z80_pkg::REG_E:  de[7:0] <= wr_data[7:0];
          z80_pkg::REG_H:  hl[15:8] <= wr_data[7:0];
          z80_pkg::REG_L:  hl[7:0] <= wr_data[7:0];
          z80_pkg::REG_BC: bc <= wr_data;
          z80_pkg::REG_DE: de <= wr_data;
          z80_pkg::REG_HL: hl <= wr_data;
          z80_pkg::REG_SP: sp <= wr_data;
          z80_pkg::REG_AF: af <= wr_data;
          z80_pkg::REG_IX: ix <= wr_data;
          z80_pkg::REG_IY: iy <= wr_data;
          default: ;
        endcase
      end else if (do_inc || do_dec) begin
        // CPI and CPD leave DE alone
        if (!block_compare) begin
          de <= do_inc ? de + 16'd1 : de - 16'd1;
        end
        hl <= do_inc ? hl + 16'd1 : hl - 16'd1;
        bc <= new_bc;
        af[7:0] <= blk_flags;
      end else if (do_ex_de_hl) begin
        de <= hl;
        hl <= de;
      end else if (do_ex_af) begin
        af <= af2;
        af2 <= af;
      end else if (do_exx) begin
        bc <= bc2;
        de <= de2;
        hl <= hl2;
        bc2 <= bc;
        de2 <= de;
        hl2 <= hl;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/z80_datapath_tb.sv
`timescale 1ns/10ps
`default_nettype none

module z80_datapath_tb;

  localparam int TIMEOUT = 20;

  logic               clk;
  logic               reset;
  logic               cmd_req;
  z80_pkg::cmd_word_u cmd_word;
  logic               cmd_ack;
  logic [15:0]        rd_data;
  logic [7:0]         flags;

  // Reference copies of every 16-bit register
  logic [15:0] m_af, m_bc, m_de, m_hl, m_af2, m_bc2, m_de2, m_hl2, m_ix, m_iy, m_sp;
  integer      seed;
  logic [31:0] r;
  logic [31:0] r2;

  z80_datapath DUT (
    .clk(clk), .reset(reset), .cmd_req(cmd_req), .cmd_word(cmd_word),
    .cmd_ack(cmd_ack), .rd_data(rd_data), .flags(flags)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic z80_pkg::cmd_word_u reg_cmd(input z80_pkg::cmd_op_t op,
                                                 input z80_pkg::reg_select_t sel,
                                                 input logic [15:0] imm);
    z80_pkg::cmd_word_u w;
    w = '0;
    w.regs.op = op;
    w.regs.sel = sel;
    w.regs.imm = imm;
    return w;
  endfunction

  function automatic z80_pkg::cmd_word_u alu_cmd(input z80_pkg::alu_fn_t fn,
                                                 input z80_pkg::reg_select_t sa,
                                                 input z80_pkg::reg_select_t sb,
                                                 input z80_pkg::reg_select_t dst);
    z80_pkg::cmd_word_u w;
    w = '0;
    w.alu.op = z80_pkg::OP_ALU;
    w.alu.fn = fn;
    w.alu.src_a = sa;
    w.alu.src_b = sb;
    w.alu.dest = dst;
    return w;
  endfunction

  // 0..6 are the 8-bit registers, 7..13 the pairs
  function automatic z80_pkg::reg_select_t pick_sel(input int idx);
    case (idx)
      0: return z80_pkg::REG_A;
      1: return z80_pkg::REG_B;
      2: return z80_pkg::REG_C;
      3: return z80_pkg::REG_D;
      4: return z80_pkg::REG_E;
      5: return z80_pkg::REG_H;
      6: return z80_pkg::REG_L;
      7: return z80_pkg::REG_BC;
      8: return z80_pkg::REG_DE;
      9: return z80_pkg::REG_HL;
      10: return z80_pkg::REG_SP;
      11: return z80_pkg::REG_AF;
      12: return z80_pkg::REG_IX;
      default: return z80_pkg::REG_IY;
    endcase
  endfunction

  function automatic logic [15:0] model_read(input z80_pkg::reg_select_t sel);
    case (sel)
      z80_pkg::REG_A:  return {8'h00, m_af[15:8]};
      z80_pkg::REG_B:  return {8'h00, m_bc[15:8]};
      z80_pkg::REG_C:  return {8'h00, m_bc[7:0]};
      z80_pkg::REG_D:  return {8'h00, m_de[15:8]};
      z80_pkg::REG_E:  return {8'h00, m_de[7:0]};
      z80_pkg::REG_H:  return {8'h00, m_hl[15:8]};
      z80_pkg::REG_L:  return {8'h00, m_hl[7:0]};
      z80_pkg::REG_BC: return m_bc;
      z80_pkg::REG_DE: return m_de;
      z80_pkg::REG_HL: return m_hl;
      z80_pkg::REG_SP: return m_sp;
      z80_pkg::REG_AF: return m_af;
      z80_pkg::REG_IX: return m_ix;
      default:         return m_iy;
    endcase
  endfunction

  task automatic model_write(input z80_pkg::reg_select_t sel, input logic [15:0] val);
    case (sel)
      z80_pkg::REG_A:  m_af[15:8] = val[7:0];
      z80_pkg::REG_B:  m_bc[15:8] = val[7:0];
      z80_pkg::REG_C:  m_bc[7:0] = val[7:0];
      z80_pkg::REG_D:  m_de[15:8] = val[7:0];
      z80_pkg::REG_E:  m_de[7:0] = val[7:0];
      z80_pkg::REG_H:  m_hl[15:8] = val[7:0];
      z80_pkg::REG_L:  m_hl[7:0] = val[7:0];
      z80_pkg::REG_BC: m_bc = val;
      z80_pkg::REG_DE: m_de = val;
      z80_pkg::REG_HL: m_hl = val;
      z80_pkg::REG_SP: m_sp = val;
      z80_pkg::REG_AF: m_af = val;
      z80_pkg::REG_IX: m_ix = val;
      default:         m_iy = val;
    endcase
  endtask

  // Four-phase handshake, called and returning on a falling edge
  task automatic send(input z80_pkg::cmd_word_u w, input int hold, output logic [15:0] data);
    int n;
    cmd_word = w;
    cmd_req = 1'b1;
    n = 0;
    while (!cmd_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ack) report_timeout("cmd_ack did not rise after cmd_req");
    check_value("ack rise latency", 16'd2, 16'(n));
    data = rd_data;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("ack held while req high", 16'd1, {15'd0, cmd_ack});
    end
    cmd_req = 1'b0;
    n = 0;
    while (cmd_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (cmd_ack) report_timeout("cmd_ack stayed high after cmd_req dropped");
    check_value("ack fall latency", 16'd1, 16'(n));
  endtask

  task automatic load(input z80_pkg::reg_select_t sel, input logic [15:0] val);
    logic [15:0] data;
    send(reg_cmd(z80_pkg::OP_LOAD, sel, val), 0, data);
    model_write(sel, val);
  endtask

  task automatic read_check(input string name, input z80_pkg::reg_select_t sel);
    logic [15:0] data;
    send(reg_cmd(z80_pkg::OP_READ, sel, 16'h0000), 0, data);
    check_value(name, model_read(sel), data);
    check_value({name, " flags"}, {8'h00, m_af[7:0]}, {8'h00, flags});
  endtask

  task automatic check_all(input string name);
    read_check(name, z80_pkg::REG_BC);
    read_check(name, z80_pkg::REG_DE);
    read_check(name, z80_pkg::REG_HL);
    read_check(name, z80_pkg::REG_AF);
    read_check(name, z80_pkg::REG_SP);
    read_check(name, z80_pkg::REG_IX);
    read_check(name, z80_pkg::REG_IY);
  endtask

  // Loads both operands, runs the op and checks dest and F
  task automatic run_alu(input z80_pkg::alu_fn_t fn, input z80_pkg::reg_select_t sa,
                         input z80_pkg::reg_select_t sb, input z80_pkg::reg_select_t dst,
                         input logic [7:0] va, input logic [7:0] vb);
    logic [15:0] data;
    logic [15:0] ta;
    logic [15:0] tb;
    logic [7:0]  res;
    logic [4:0]  nib;
    logic        h;
    logic        pv;
    logic        c;
    int          s;
    load(sa, {8'h00, va});
    load(sb, {8'h00, vb});
    ta = model_read(sa);
    tb = model_read(sb);
    send(alu_cmd(fn, sa, sb, dst), 0, data);
    case (fn)
      z80_pkg::ALU_ADD: begin
        res = ta[7:0] + tb[7:0];
        s = int'($signed(ta[7:0])) + int'($signed(tb[7:0]));
        nib = {1'b0, ta[3:0]} + {1'b0, tb[3:0]};
        h = nib[4];
        c = ({1'b0, ta[7:0]} + {1'b0, tb[7:0]}) > 9'd255;
        pv = (s > 127) || (s < -128);
      end
      z80_pkg::ALU_SUB: begin
        res = ta[7:0] - tb[7:0];
        s = int'($signed(ta[7:0])) - int'($signed(tb[7:0]));
        nib = {1'b0, ta[3:0]} - {1'b0, tb[3:0]};
        h = nib[4];
        c = ta[7:0] < tb[7:0];
        pv = (s > 127) || (s < -128);
      end
      z80_pkg::ALU_AND: begin
        res = ta[7:0] & tb[7:0];
        h = 1'b1;
        c = 1'b0;
        pv = ($countones(res) % 2) == 0;
      end
      default: begin
        res = ta[7:0] ^ tb[7:0];
        h = 1'b0;
        c = 1'b0;
        pv = ($countones(res) % 2) == 0;
      end
    endcase
    model_write(dst, {8'h00, res});
    m_af[7:0] = {res[7], res == 8'h00, res[5], h, res[3], pv, fn == z80_pkg::ALU_SUB, c};
    read_check("alu result", dst);
  endtask

  task automatic block_step(input z80_pkg::cmd_op_t op, input logic inc, input logic cmp);
    logic [15:0] data;
    logic [15:0] nbc;
    send(reg_cmd(op, z80_pkg::REG_B, 16'h0000), 0, data);
    nbc = m_bc - 16'd1;
    if (!cmp) m_de = inc ? m_de + 16'd1 : m_de - 16'd1;
    m_hl = inc ? m_hl + 16'd1 : m_hl - 16'd1;
    m_bc = nbc;
    m_af[z80_pkg::FLAG_PV] = nbc != 16'h0000;
    if (!cmp) begin
      m_af[z80_pkg::FLAG_H] = 1'b0;
      m_af[z80_pkg::FLAG_N] = 1'b0;
    end
    check_all("block step");
  endtask

  task automatic exchange(input z80_pkg::cmd_op_t op);
    logic [15:0] data;
    send(reg_cmd(op, z80_pkg::REG_B, 16'h0000), 0, data);
    case (op)
      z80_pkg::OP_EX_DE_HL: {m_de, m_hl} = {m_hl, m_de};
      z80_pkg::OP_EX_AF:    {m_af, m_af2} = {m_af2, m_af};
      default: {m_bc, m_de, m_hl, m_bc2, m_de2, m_hl2} = {m_bc2, m_de2, m_hl2, m_bc, m_de, m_hl};
    endcase
    check_all("exchange");
  endtask

  initial begin
    z80_pkg::reg_select_t sa;
    z80_pkg::reg_select_t sb;
    z80_pkg::reg_select_t dst;
    logic [15:0]          data;
    seed = 32'h1a36;
    clk = 1'b0;
    reset = 1'b1;
    cmd_req = 1'b0;
    cmd_word = '0;
    {m_af, m_bc, m_de, m_hl, m_af2, m_bc2, m_de2, m_hl2, m_ix, m_iy, m_sp} = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    check_value("reset ack", 16'd0, {15'd0, cmd_ack});
    check_value("reset rd_data", 16'h0000, rd_data);
    for (int i = 0; i < 14; i++) read_check("reset read", pick_sel(i));

    // Host keeps req high for a few cycles
    send(reg_cmd(z80_pkg::OP_LOAD, z80_pkg::REG_SP, 16'h1234), 3, data);
    model_write(z80_pkg::REG_SP, 16'h1234);
    read_check("held load", z80_pkg::REG_SP);

    repeat (30) begin
      r = $random(seed);
      r2 = $random(seed);
      sa = pick_sel(int'(r % 32'd14));
      load(sa, r2[15:0]);
      read_check("load readback", sa);
    end
    r = $random(seed);
    load(z80_pkg::REG_BC, r[15:0]);
    load(z80_pkg::REG_B, {8'h00, r[23:16]});
    read_check("B in BC high byte", z80_pkg::REG_BC);
    // Every flag bit flips
    load(z80_pkg::REG_AF, {r[31:24], ~m_af[7:0]});
    read_check("AF load", z80_pkg::REG_AF);

    // Overflow, half carry and zero corners
    run_alu(z80_pkg::ALU_ADD, z80_pkg::REG_B, z80_pkg::REG_C, z80_pkg::REG_A, 8'h7f, 8'h01);
    run_alu(z80_pkg::ALU_SUB, z80_pkg::REG_D, z80_pkg::REG_E, z80_pkg::REG_H, 8'h80, 8'h01);
    run_alu(z80_pkg::ALU_ADD, z80_pkg::REG_L, z80_pkg::REG_B, z80_pkg::REG_C, 8'h0f, 8'h01);
    run_alu(z80_pkg::ALU_SUB, z80_pkg::REG_A, z80_pkg::REG_C, z80_pkg::REG_D, 8'h10, 8'h01);
    run_alu(z80_pkg::ALU_XOR, z80_pkg::REG_E, z80_pkg::REG_H, z80_pkg::REG_L, 8'h5a, 8'h5a);
    run_alu(z80_pkg::ALU_ADD, z80_pkg::REG_A, z80_pkg::REG_B, z80_pkg::REG_A, 8'hff, 8'h01);
    run_alu(z80_pkg::ALU_AND, z80_pkg::REG_C, z80_pkg::REG_D, z80_pkg::REG_E, 8'hf0, 8'h0f);
    repeat (40) begin
      r = $random(seed);
      r2 = $random(seed);
      sa = pick_sel(int'(r[15:8] % 8'd7));
      sb = pick_sel(int'(r[23:16] % 8'd7));
      dst = pick_sel(int'(r[31:24] % 8'd7));
      run_alu(z80_pkg::alu_fn_t'(r[1:0]), sa, sb, dst, r2[7:0], r2[15:8]);
    end

    // Block steps start with H and N set, the first one with PV clear
    r = $random(seed);
    r2 = $random(seed);
    load(z80_pkg::REG_HL, r[15:0]);
    load(z80_pkg::REG_DE, r[31:16]);
    load(z80_pkg::REG_BC, r2[15:0] | 16'h0100);
    load(z80_pkg::REG_AF, 16'h00fb);
    block_step(z80_pkg::OP_BLOCK_INC, 1'b1, 1'b0);
    load(z80_pkg::REG_AF, 16'h00ff);
    block_step(z80_pkg::OP_BLOCK_CPI, 1'b1, 1'b1);
    block_step(z80_pkg::OP_BLOCK_DEC, 1'b0, 1'b0);
    load(z80_pkg::REG_AF, 16'h00ff);
    block_step(z80_pkg::OP_BLOCK_CPD, 1'b0, 1'b1);
    // Count reaching zero clears PV
    load(z80_pkg::REG_BC, 16'h0001);
    block_step(z80_pkg::OP_BLOCK_DEC, 1'b0, 1'b0);
    load(z80_pkg::REG_BC, 16'h0001);
    load(z80_pkg::REG_AF, 16'h00ff);
    block_step(z80_pkg::OP_BLOCK_CPI, 1'b1, 1'b1);

    // Give the shadow set values of its own
    exchange(z80_pkg::OP_EXX);
    r = $random(seed);
    r2 = $random(seed);
    load(z80_pkg::REG_BC, r[15:0]);
    load(z80_pkg::REG_DE, r[31:16]);
    load(z80_pkg::REG_HL, r2[15:0]);
    exchange(z80_pkg::OP_EX_AF);
    load(z80_pkg::REG_AF, r2[31:16]);
    exchange(z80_pkg::OP_EX_DE_HL);
    exchange(z80_pkg::OP_EX_DE_HL);
    exchange(z80_pkg::OP_EX_AF);
    exchange(z80_pkg::OP_EX_AF);
    exchange(z80_pkg::OP_EXX);
    exchange(z80_pkg::OP_EXX);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
